//--- logic/umode_pkg.sv
`default_nettype none

package umode_pkg;

  // Only U and M privilege modes exist on this core
  typedef logic [1:0] mode_t;

  localparam mode_t MODE_U = 2'b00;
  localparam mode_t MODE_M = 2'b11;

  // mstatus fields
  localparam int MPP_POS  = 11;
  localparam int MPP_LEN  = 2;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;

  // misa extension bits
  localparam int MISA_U_POS = 20;
  localparam int MISA_S_POS = 18;
  localparam int MISA_N_POS = 13;

  // System instruction encodings
  localparam logic [6:0]  SYSTEM_OPCODE = 7'b1110011;
  localparam logic [31:0] MRET_IDATA    = 32'h3020_0073;
  localparam logic [31:0] WFI_IDATA     = 32'h1050_0073;
  localparam logic [31:0] URET_IDATA    = 32'h0020_0073;
  localparam logic [31:0] ECALL_IDATA   = 32'h0000_0073;
  localparam logic [31:0] CUSTOM0_IDATA = {6'b100011, 11'd0, 3'b000, 5'd0, SYSTEM_OPCODE};
  localparam logic [31:0] CUSTOM1_IDATA = {6'b110011, 11'd0, 3'b000, 5'd0, SYSTEM_OPCODE};
  localparam logic [31:0] CUSTOM_IMASK  = {6'b111111, 11'd0, 3'b111, 5'd0, 7'b1111111};

  // Exception causes
  localparam logic [5:0] CAUSE_INSTR_FAULT  = 6'd1;
  localparam logic [5:0] CAUSE_ILLEGAL_INSN = 6'd2;
  localparam logic [5:0] CAUSE_ECALL_U      = 6'd8;
  localparam logic [5:0] CAUSE_PRIO_A       = 6'd24;
  localparam logic [5:0] CAUSE_PRIO_B       = 6'd25;

  // One flag per rule
  localparam int NUM_RULES = 9;

  localparam int R_MODE_UNSUP   = 0;
  localparam int R_MISA_BITS    = 1;
  localparam int R_MPP_LEGAL    = 2;
  localparam int R_UMODE_MPRV   = 3;
  localparam int R_TRAP_TO_M    = 4;
  localparam int R_MRET_TARGET  = 5;
  localparam int R_ECALL_U      = 6;
  localparam int R_PRIV_ILLEGAL = 7;
  localparam int R_WFI_LEGAL    = 8;

  typedef logic [NUM_RULES-1:0] rule_vec_t;

endpackage

`default_nettype wire

//--- logic/retire_decode.sv
`timescale 1ns/1ps
`default_nettype none

module retire_decode
  import umode_pkg::*;
(
  input  wire logic [31:0] retire_insn,
  input  wire logic        retire_trap,
  input  wire logic [5:0]  retire_cause,
  output logic             is_mret,
  output logic             is_wfi,
  output logic             is_ecall,
  output logic             is_uret,
  output logic             is_custom,
  output logic             is_csr_priv,
  output logic             trap_illegal,
  output logic             trap_prio
);

  logic [2:0] funct3;
  logic       is_system;
  logic       is_csr;

  assign funct3    = retire_insn[14:12];
  assign is_system = (retire_insn[6:0] == SYSTEM_OPCODE);

  // Exact encodings
  assign is_mret  = (retire_insn == MRET_IDATA);
  assign is_wfi   = (retire_insn == WFI_IDATA);
  assign is_ecall = (retire_insn == ECALL_IDATA);
  assign is_uret  = (retire_insn == URET_IDATA);

  // Both custom encodings share one mask
  assign is_custom = ((retire_insn & CUSTOM_IMASK) == CUSTOM0_IDATA) ||
                     ((retire_insn & CUSTOM_IMASK) == CUSTOM1_IDATA);

  // csrrw/csrrs/csrrc and their immediate forms
  assign is_csr = is_system && (funct3 != 3'd0) && (funct3 != 3'd4);

  // CSR address bits 9:8 give the lowest level allowed to access it
  assign is_csr_priv = is_csr && (retire_insn[29:28] != 2'b00);

  assign trap_illegal = retire_trap && (retire_cause == CAUSE_ILLEGAL_INSN);

  // Causes that outrank an illegal-instruction trap
  assign trap_prio = retire_trap &&
                     (retire_cause inside {CAUSE_INSTR_FAULT, CAUSE_PRIO_A, CAUSE_PRIO_B});

  // Exact-match classes must never overlap
  always_comb begin
    a_one_class: assert ($onehot0({is_mret, is_wfi, is_ecall, is_uret}))
      else $error("retire_decode: more than one instruction class matched %h", retire_insn);
  end

endmodule

`default_nettype wire

//--- logic/retire_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module retire_tracker
  import umode_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n,
  input  wire logic        retire_valid,
  input  wire mode_t       retire_mode,
  input  wire logic        retire_trap,
  input  wire logic        is_mret,
  input  wire logic [31:0] mstatus_rdata,
  output logic             prev_valid,
  output logic             prev_trap,
  output logic             prev_mret_m,
  output mode_t            prev_mpp
);

  logic mret_m_ok;

  // Successful mret executed from machine mode
  assign mret_m_ok = is_mret && (retire_mode == MODE_M) && !retire_trap;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      prev_valid  <= 1'b0;
      prev_trap   <= 1'b0;
      prev_mret_m <= 1'b0;
    end else if (retire_valid) begin
      prev_valid  <= 1'b1;
      prev_trap   <= retire_trap;
      prev_mret_m <= mret_m_ok;
    end
  end

  // MPP read by the retiring instruction becomes the mret target
  always_ff @(posedge clk_i) begin
    if (retire_valid) begin
      prev_mpp <= mstatus_rdata[MPP_POS +: MPP_LEN];
    end
  end

  // History stays valid until the next reset
  a_prev_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    prev_valid |=> prev_valid
  ) else $error("retire_tracker: prev_valid dropped without reset");

endmodule

`default_nettype wire

//--- logic/priv_rule_check.sv
`timescale 1ns/1ps
`default_nettype none

module priv_rule_check
  import umode_pkg::*;
#(
  parameter int CNT_W = 16
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n,
  input  wire logic        retire_valid,
  input  wire mode_t       retire_mode,
  input  wire logic        retire_trap,
  input  wire logic [5:0]  retire_cause,
  input  wire logic [31:0] mstatus_rdata,
  input  wire logic [31:0] mstatus_wdata,
  input  wire logic [31:0] mstatus_wmask,
  input  wire logic [31:0] misa_rdata,
  input  wire logic        is_mret,
  input  wire logic        is_wfi,
  input  wire logic        is_ecall,
  input  wire logic        is_uret,
  input  wire logic        is_custom,
  input  wire logic        is_csr_priv,
  input  wire logic        trap_illegal,
  input  wire logic        trap_prio,
  input  wire logic        prev_valid,
  input  wire logic        prev_trap,
  input  wire logic        prev_mret_m,
  input  wire mode_t       prev_mpp,
  output logic             viol_valid,
  output rule_vec_t        viol_flags,
  output logic [CNT_W-1:0] viol_count
);

  localparam int FLAG_CNT_W = $clog2(NUM_RULES + 1);

  logic [31:0]           mstatus_post;
  mode_t                 post_mpp;
  logic                  in_umode;
  logic                  tw;
  logic                  priv_insn;
  rule_vec_t             rule_flags;
  logic [FLAG_CNT_W-1:0] flag_cnt;
  logic [CNT_W:0]        cnt_sum;

  // mstatus after the write takes masked bits from wdata
  assign mstatus_post = (mstatus_wdata & mstatus_wmask) | (mstatus_rdata & ~mstatus_wmask);
  assign post_mpp     = mstatus_post[MPP_POS +: MPP_LEN];

  assign in_umode = (retire_mode == MODE_U);
  assign tw       = mstatus_rdata[TW_POS];

  // Everything U-mode must not execute
  assign priv_insn = is_mret || is_uret || is_custom || is_csr_priv || (is_wfi && tw);

  always_comb begin
    rule_flags = '0;
    rule_flags[R_MODE_UNSUP] = !(retire_mode inside {MODE_U, MODE_M});
    rule_flags[R_MISA_BITS]  = !misa_rdata[MISA_U_POS] || misa_rdata[MISA_S_POS] ||
                               misa_rdata[MISA_N_POS];
    rule_flags[R_MPP_LEGAL]  = !(post_mpp inside {MODE_U, MODE_M});
    rule_flags[R_UMODE_MPRV] = in_umode && mstatus_rdata[MPRV_POS];

    // Rules against the previous retirement
    rule_flags[R_TRAP_TO_M]   = prev_valid && prev_trap && (retire_mode != MODE_M);
    rule_flags[R_MRET_TARGET] = prev_valid && prev_mret_m && (retire_mode != prev_mpp);

    rule_flags[R_ECALL_U] = is_ecall && in_umode &&
                            !((retire_trap && (retire_cause == CAUSE_ECALL_U)) || trap_prio);
    rule_flags[R_PRIV_ILLEGAL] = in_umode && priv_insn && !(trap_illegal || trap_prio);
    rule_flags[R_WFI_LEGAL]    = in_umode && is_wfi && !tw && trap_illegal;
  end

  // Number of broken rules this retirement
  always_comb begin
    flag_cnt = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      flag_cnt = flag_cnt + FLAG_CNT_W'(rule_flags[i]);
    end
  end

  assign cnt_sum = {1'b0, viol_count} + (CNT_W + 1)'(flag_cnt);

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      viol_valid <= 1'b0;
      viol_flags <= '0;
      viol_count <= '0;
    end else begin
      viol_valid <= retire_valid;
      viol_flags <= retire_valid ? rule_flags : '0;
      if (retire_valid) begin
        // Saturate on carry out
        viol_count <= cnt_sum[CNT_W] ? '1 : cnt_sum[CNT_W-1:0];
      end
    end
  end

  a_one_report: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    viol_valid == $past(retire_valid)
  ) else $error("priv_rule_check: viol_valid does not follow retire_valid");

endmodule

`default_nettype wire

//--- logic/umode_checker_top.sv
`timescale 1ns/1ps
`default_nettype none

module umode_checker_top
  import umode_pkg::*;
#(
  parameter int CNT_W = 16
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n,
  input  wire logic        retire_valid,
  input  wire mode_t       retire_mode,
  input  wire logic [31:0] retire_insn,
  input  wire logic        retire_trap,
  input  wire logic [5:0]  retire_cause,
  input  wire logic [31:0] mstatus_rdata,
  input  wire logic [31:0] mstatus_wdata,
  input  wire logic [31:0] mstatus_wmask,
  input  wire logic [31:0] misa_rdata,
  output logic             viol_valid,
  output rule_vec_t        viol_flags,
  output logic [CNT_W-1:0] viol_count
);

  // Instruction and trap classes
  logic  is_mret;
  logic  is_wfi;
  logic  is_ecall;
  logic  is_uret;
  logic  is_custom;
  logic  is_csr_priv;
  logic  trap_illegal;
  logic  trap_prio;

  // Previous retirement
  logic  prev_valid;
  logic  prev_trap;
  logic  prev_mret_m;
  mode_t prev_mpp;

  retire_decode u_decode (
    .retire_insn  (retire_insn),
    .retire_trap  (retire_trap),
    .retire_cause (retire_cause),
    .is_mret      (is_mret),
    .is_wfi       (is_wfi),
    .is_ecall     (is_ecall),
    .is_uret      (is_uret),
    .is_custom    (is_custom),
    .is_csr_priv  (is_csr_priv),
    .trap_illegal (trap_illegal),
    .trap_prio    (trap_prio)
  );

  retire_tracker u_tracker (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .retire_valid  (retire_valid),
    .retire_mode   (retire_mode),
    .retire_trap   (retire_trap),
    .is_mret       (is_mret),
    .mstatus_rdata (mstatus_rdata),
    .prev_valid    (prev_valid),
    .prev_trap     (prev_trap),
    .prev_mret_m   (prev_mret_m),
    .prev_mpp      (prev_mpp)
  );

  priv_rule_check #(
    .CNT_W (CNT_W)
  ) u_rules (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .retire_valid  (retire_valid),
    .retire_mode   (retire_mode),
    .retire_trap   (retire_trap),
    .retire_cause  (retire_cause),
    .mstatus_rdata (mstatus_rdata),
    .mstatus_wdata (mstatus_wdata),
    .mstatus_wmask (mstatus_wmask),
    .misa_rdata    (misa_rdata),
    .is_mret       (is_mret),
    .is_wfi        (is_wfi),
    .is_ecall      (is_ecall),
    .is_uret       (is_uret),
    .is_custom     (is_custom),
    .is_csr_priv   (is_csr_priv),
    .trap_illegal  (trap_illegal),
    .trap_prio     (trap_prio),
    .prev_valid    (prev_valid),
    .prev_trap     (prev_trap),
    .prev_mret_m   (prev_mret_m),
    .prev_mpp      (prev_mpp),
    .viol_valid    (viol_valid),
    .viol_flags    (viol_flags),
    .viol_count    (viol_count)
  );

endmodule

`default_nettype wire

//--- sim/umode_checker_tb.sv
`timescale 1ns/1ps
`default_nettype none

module umode_checker_tb
  import umode_pkg::*;
();

  localparam int CNT_W      = 16;
  localparam int CLK_PERIOD = 4;
  localparam int FIELDS     = 10;
  localparam int ADDR_W     = 10;
  localparam int MAX_LINES  = (2 ** ADDR_W) / FIELDS;

  logic             clk_i;
  logic             rst_n;
  logic             retire_valid;
  mode_t            retire_mode;
  logic [31:0]      retire_insn;
  logic             retire_trap;
  logic [5:0]       retire_cause;
  logic [31:0]      mstatus_rdata;
  logic [31:0]      mstatus_wdata;
  logic [31:0]      mstatus_wmask;
  logic [31:0]      misa_rdata;
  logic             viol_valid;
  rule_vec_t        viol_flags;
  logic [CNT_W-1:0] viol_count;

  // Ten words per retirement as listed in the trace column line
  logic [31:0] trace_mem [0:2**ADDR_W-1];
  int          trace_len;
  logic        trace_loaded;
  rule_vec_t   exp_queue [$];
  int          exp_sum;
  int          report_sum;
  int          value_errs;
  int          protocol_errs;
  logic        valid_seen;
  logic [31:0] rnd_state;

  umode_checker_top #(
    .CNT_W (CNT_W)
  ) UUT (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .retire_valid  (retire_valid),
    .retire_mode   (retire_mode),
    .retire_insn   (retire_insn),
    .retire_trap   (retire_trap),
    .retire_cause  (retire_cause),
    .mstatus_rdata (mstatus_rdata),
    .mstatus_wdata (mstatus_wdata),
    .mstatus_wmask (mstatus_wmask),
    .misa_rdata    (misa_rdata),
    .viol_valid    (viol_valid),
    .viol_flags    (viol_flags),
    .viol_count    (viol_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int count_flags(input rule_vec_t v);
    int n;
    n = 0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (v[i]) n++;
    end
    return n;
  endfunction

  function automatic logic [31:0] trace_field(input int line, input int col);
    logic [ADDR_W-1:0] addr;
    addr = ADDR_W'(line * FIELDS + col);
    return trace_mem[addr];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("ERR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        value_errs++;
      end
  endtask

  // Drive one trace line and queue its expected flags
  task automatic apply_line(input int idx);
    logic [31:0] valid_w;
    logic [31:0] mode_w;
    logic [31:0] trap_w;
    logic [31:0] cause_w;
    logic [31:0] exp_w;
    valid_w = trace_field(idx, 0);
    mode_w  = trace_field(idx, 1);
    trap_w  = trace_field(idx, 3);
    cause_w = trace_field(idx, 4);
    exp_w   = trace_field(idx, 9);
    retire_valid  <= valid_w[0];
    retire_mode   <= mode_w[1:0];
    retire_insn   <= trace_field(idx, 2);
    retire_trap   <= trap_w[0];
    retire_cause  <= cause_w[5:0];
    mstatus_rdata <= trace_field(idx, 5);
    mstatus_wdata <= trace_field(idx, 6);
    mstatus_wmask <= trace_field(idx, 7);
    misa_rdata    <= trace_field(idx, 8);
    if (valid_w[0]) begin
      exp_queue.push_back(exp_w[NUM_RULES-1:0]);
      exp_sum += count_flags(exp_w[NUM_RULES-1:0]);
    end
  endtask

  initial begin
    int gap;
    rst_n         = 1'b0;
    retire_valid  = 1'b0;
    retire_mode   = MODE_M;
    retire_insn   = '0;
    retire_trap   = 1'b0;
    retire_cause  = '0;
    mstatus_rdata = '0;
    mstatus_wdata = '0;
    mstatus_wmask = '0;
    misa_rdata    = '0;
    exp_sum       = 0;
    report_sum    = 0;
    value_errs    = 0;
    protocol_errs = 0;
    rnd_state     = 32'h1cab_2a78;
    trace_len     = 0;
    trace_loaded  = 1'b0;

    $readmemh("sim/umode_trace.hex", trace_mem);
    // All ones in the valid column ends the trace
    while (trace_len < MAX_LINES && trace_field(trace_len, 0) != 32'hffff_ffff) begin
      trace_len++;
    end
    trace_loaded = 1'b1;

    repeat (2) @(posedge clk_i);
    rst_n <= 1'b1;

    @(negedge clk_i);
    check_value("viol_valid", 32'(0), 32'(viol_valid));
    check_value("viol_flags", 32'(0), 32'(viol_flags));
    check_value("viol_count", 32'(0), 32'(viol_count));

    for (int i = 0; i < trace_len; i++) begin
      @(posedge clk_i);
      apply_line(i);
      // Random idle gap that is often zero so lines also run back to back
      rnd_state = xorshift32(rnd_state);
      gap = rnd_state[7] ? int'(rnd_state[1:0]) + 1 : 0;
      repeat (gap) begin
        @(posedge clk_i);
        retire_valid <= 1'b0;
      end
    end
    @(posedge clk_i);
    retire_valid <= 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);

    assert (exp_queue.size() == 0)
      else begin
        $display("%0d retirements never got a report from the checker", exp_queue.size());
        protocol_errs++;
      end
    check_value("viol_count", 32'(exp_sum), 32'(viol_count));

    $display("Errors: %0d value, %0d protocol", value_errs, protocol_errs);
    if (value_errs == 0 && protocol_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Outputs sampled mid-cycle against the retirement seen one cycle before
  always @(negedge clk_i) begin
    rule_vec_t exp_flags;
    if (!rst_n) begin
      valid_seen = 1'b0;
    end else begin
      assert (viol_valid === valid_seen)
        else begin
          if (valid_seen) begin
            $display("Checker missed the report for a retirement at %0t", $time);
          end else begin
            $display("Checker reported without a retirement at %0t", $time);
          end
          protocol_errs++;
        end
      if (viol_valid) begin
        assert (exp_queue.size() > 0)
          else begin
            $display("Report at %0t has no queued retirement to match", $time);
            protocol_errs++;
          end
        if (exp_queue.size() > 0) begin
          exp_flags = exp_queue.pop_front();
          report_sum += count_flags(exp_flags);
          check_value("viol_flags", 32'(exp_flags), 32'(viol_flags));
          // Counter already includes this retirement
          check_value("viol_count", 32'(report_sum), 32'(viol_count));
        end
      end
      valid_seen = retire_valid;
    end
  end

  // Each line takes at most 5 cycles including its gap
  initial begin
    wait (trace_loaded === 1'b1);
    repeat (trace_len * 8 + 100) @(posedge clk_i);
    $display("Watchdog expired, trace replay did not finish in %0d cycles",
             trace_len * 8 + 100);
    $display("Errors: %0d value, %0d protocol", value_errs, protocol_errs);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
logic/umode_pkg.sv
logic/retire_decode.sv
logic/retire_tracker.sv
logic/priv_rule_check.sv
logic/umode_checker_top.sv
sim/umode_checker_tb.sv

//--- Makefile
# Verilator build and run for the U-mode privilege checker

VERILATOR ?= verilator
TOP       ?= umode_checker_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx 'TEST PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/umode_trace.hex
// valid mode insn trap cause mstatus_rdata mstatus_wdata mstatus_wmask misa expected_flags
// expected_flags bit order: mode misa mpp mprv trap_to_m mret_target ecall_u priv_illegal wfi
1 0 00000013 0 00 00000000 00000000 00000000 40101100 000
1 2 00000013 0 00 00001800 00000000 00000000 40101100 001
1 3 00000013 0 00 00001800 00000000 00000000 40141100 002
1 3 00000013 0 00 00001800 00000000 00000000 40001100 002
1 3 30001073 0 00 00001800 00000800 00001800 40101100 004
1 0 00000013 0 00 00020000 00000000 00000000 40101100 008
0 0 00000000 0 00 00000000 00000000 00000000 00000000 000
1 0 00000073 1 08 00000000 00000000 00000000 40101100 000
1 3 00000013 0 00 00000000 00000000 00000000 40101100 000
1 0 00000073 1 02 00000000 00000000 00000000 40101100 040
1 0 00000013 0 00 00000000 00000000 00000000 40101100 010
1 3 30200073 0 00 00000000 00000000 00000000 40101100 000
1 3 00000013 0 00 00000000 00000000 00000000 40101100 020
1 3 30200073 0 00 00001800 00000000 00000000 40101100 000
1 3 00000013 0 00 00001800 00000000 00000000 40101100 000
1 3 30200073 0 00 00000000 00000000 00000000 40101100 000
1 0 00000013 0 00 00000000 00000000 00000000 40101100 000
1 0 30200073 0 00 00000000 00000000 00000000 40101100 080
1 0 00200073 0 00 00000000 00000000 00000000 40101100 080
1 0 8c000073 0 00 00000000 00000000 00000000 40101100 080
1 0 300020f3 0 00 00000000 00000000 00000000 40101100 080
1 0 10500073 0 00 00200000 00000000 00000000 40101100 080
1 0 c00020f3 0 00 00000000 00000000 00000000 40101100 000
1 0 10500073 1 02 00000000 00000000 00000000 40101100 100
1 3 00000013 0 00 00000000 00000000 00000000 40101100 000
1 0 cc000073 1 01 00000000 00000000 00000000 40101100 000
1 3 00000013 0 00 00000000 00000000 00000000 40101100 000
1 0 00000073 1 19 00000000 00000000 00000000 40101100 000
1 3 00000013 0 00 00000000 00000000 00000000 40101100 000
1 0 00200073 1 18 00000000 00000000 00000000 40101100 000
1 3 00000013 0 00 00000000 00000000 00000000 40101100 000
1 0 10500073 1 05 00200000 00000000 00000000 40101100 080
1 0 00000013 0 00 00020000 00000000 00000000 40001100 01a
ffffffff
